// ==== src/perf_cnt_pkg.sv ====
// **************************************************
// Performance counter unit package
// CSR operations, address map and data widths
// **************************************************

package perf_cnt_pkg;

  // CSR access operations
  typedef enum logic [1:0] {
    CSR_READ  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_e;

  // Widths
  localparam int CsrAddrW = 12;
  localparam int CsrDataW = 32;
  localparam int CntValW  = 64;

  // Upper bound on implemented counters
  localparam int MaxCounters = 8;

  // Address map
  localparam logic [CsrAddrW-1:0] CSR_MCOUNTINHIBIT = 12'h320;
  localparam logic [CsrAddrW-1:0] CSR_MCYCLE        = 12'hB00;
  localparam logic [CsrAddrW-1:0] CSR_HIGH_OFS      = 12'h080;

  // Low word address of counter idx
  // 0xB01 is skipped, so instret lands on 0xB02
  function automatic logic [CsrAddrW-1:0] cnt_lo_addr(int unsigned idx);
    logic [CsrAddrW-1:0] addr;
    if (idx == 0) begin
      addr = CSR_MCYCLE;
    end else begin
      addr = CSR_MCYCLE + CsrAddrW'(idx) + 12'd1;
    end
    return addr;
  endfunction

  // High word address of counter idx
  function automatic logic [CsrAddrW-1:0] cnt_hi_addr(int unsigned idx);
    return cnt_lo_addr(idx) + CSR_HIGH_OFS;
  endfunction

endpackage

// ==== src/cnt_csr_if.sv ====
// **************************************************
// Counter CSR interface
// Links the access decoder, counter bank and readout
// **************************************************

`timescale 1ns/1ps

interface cnt_csr_if import perf_cnt_pkg::*; #(
  parameter int NumCounters = 5
);

  localparam int SelW = $clog2(NumCounters);

  // Write side
  logic [NumCounters-1:0] we_lo;
  logic [NumCounters-1:0] we_hi;
  logic [CsrDataW-1:0]    wdata;
  logic                   inhibit_we;

  // Read selection
  logic [SelW-1:0]        rd_sel;
  logic                   rd_hi;
  logic                   rd_inhibit;
  logic                   rd_illegal;

  // State from the bank
  logic [CntValW-1:0]     cnt_vals [NumCounters];
  logic [NumCounters-1:0] inhibit;

  modport decode (
    output we_lo, we_hi, wdata, inhibit_we,
    output rd_sel, rd_hi, rd_inhibit, rd_illegal,
    input  cnt_vals, inhibit
  );

  modport bank (
    input  we_lo, we_hi, wdata, inhibit_we,
    output cnt_vals, inhibit
  );

  modport readout (
    input rd_sel, rd_hi, rd_inhibit, rd_illegal,
    input cnt_vals, inhibit
  );

endinterface

// ==== src/perf_counter.sv ====
// **************************************************
// Single 64-bit performance counter
// Word-wise CSR writes, increment, narrow storage
// **************************************************

`timescale 1ns/1ps

module perf_counter #(
  parameter int CounterWidth = 64
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        counter_inc_i,
  input  logic        counter_we_i,
  input  logic        counterh_we_i,
  input  logic [31:0] counter_val_i,
  output logic [63:0] counter_val_o
);

  logic [CounterWidth-1:0] counter_q;
  logic [CounterWidth-1:0] counter_d;
  logic [CounterWidth-1:0] counter_inc;
  logic [63:0]             counter;
  logic [63:0]             counter_load;

  // Bits above the implemented width read as zero
  assign counter = 64'(counter_q);

  // Wraps at 2**CounterWidth
  assign counter_inc = counter_q + CounterWidth'(1);

  always_comb begin
    // Merge the written word with the untouched half
    if (counterh_we_i) begin
      counter_load = {counter_val_i, counter[31:0]};
    end else begin
      counter_load = {counter[63:32], counter_val_i};
    end

    // A write beats an increment
    if (counter_we_i || counterh_we_i) begin
      counter_d = counter_load[CounterWidth-1:0];
    end else if (counter_inc_i) begin
      counter_d = counter_inc;
    end else begin
      counter_d = counter_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      counter_q <= '0;
    end else begin
      counter_q <= counter_d;
    end
  end

  assign counter_val_o = counter;

  // Decoder only ever targets one half per access
  a_single_word_we: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(counter_we_i && counterh_we_i)
  );

endmodule

// ==== src/csr_access_decode.sv ====
// **************************************************
// CSR access decoder for the counter unit
// Address match, read select and read-modify-write
// **************************************************

`timescale 1ns/1ps

module csr_access_decode import perf_cnt_pkg::*; #(
  parameter int NumCounters = 5
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                csr_access_i,
  input  csr_op_e             csr_op_i,
  input  logic [CsrAddrW-1:0] csr_addr_i,
  input  logic [CsrDataW-1:0] csr_wdata_i,

  cnt_csr_if.decode           bus
);

  localparam int SelW = $clog2(NumCounters);

  logic                hit_cnt;
  logic                hit_hi;
  logic                hit_inh;
  logic [SelW-1:0]     hit_idx;
  logic                legal;
  logic                modify;
  logic [CsrDataW-1:0] old_val;
  logic [CsrDataW-1:0] new_val;

  // Counter address match, low and high words
  always_comb begin : addr_match
    hit_cnt = 1'b0;
    hit_hi  = 1'b0;
    hit_idx = '0;
    for (int k = 0; k < NumCounters; k++) begin
      if (csr_addr_i == cnt_lo_addr(k)) begin
        hit_cnt = 1'b1;
        hit_hi  = 1'b0;
        hit_idx = SelW'(k);
      end
      if (csr_addr_i == cnt_hi_addr(k)) begin
        hit_cnt = 1'b1;
        hit_hi  = 1'b1;
        hit_idx = SelW'(k);
      end
    end
  end

  assign hit_inh = (csr_addr_i == CSR_MCOUNTINHIBIT);
  assign legal   = hit_cnt | hit_inh;

  // Value as it stands before this access
  always_comb begin
    if (hit_inh) begin
      old_val = CsrDataW'(bus.inhibit);
    end else if (hit_hi) begin
      old_val = bus.cnt_vals[hit_idx][CntValW-1:CsrDataW];
    end else begin
      old_val = bus.cnt_vals[hit_idx][CsrDataW-1:0];
    end
  end

  always_comb begin
    case (csr_op_i)
      CSR_WRITE: new_val = csr_wdata_i;
      CSR_SET:   new_val = old_val | csr_wdata_i;
      CSR_CLEAR: new_val = old_val & ~csr_wdata_i;
      default:   new_val = old_val;
    endcase
  end

  // Reads and unmapped addresses never write
  assign modify = csr_access_i && (csr_op_i != CSR_READ) && legal;

  always_comb begin : strobes
    bus.we_lo = '0;
    bus.we_hi = '0;
    if (modify && hit_cnt) begin
      if (hit_hi) begin
        bus.we_hi[hit_idx] = 1'b1;
      end else begin
        bus.we_lo[hit_idx] = 1'b1;
      end
    end
  end

  assign bus.inhibit_we = modify & hit_inh;
  assign bus.wdata      = new_val;

  assign bus.rd_sel     = hit_idx;
  assign bus.rd_hi      = hit_hi;
  assign bus.rd_inhibit = hit_inh;
  assign bus.rd_illegal = ~legal;

  a_one_write_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bus.we_lo, bus.we_hi, bus.inhibit_we})
  );

  a_counter_bound: assert property (
    @(posedge clk_i) NumCounters <= MaxCounters
  );

endmodule

// ==== src/counter_bank.sv ====
// **************************************************
// Counter bank with inhibit register
// Cycle, instret and fixed hardware event counters
// **************************************************

`timescale 1ns/1ps

module counter_bank import perf_cnt_pkg::*; #(
  parameter int NumCounters  = 5,
  parameter int CounterWidth = 40
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Events for counters 1 and up
  input  logic [NumCounters-2:0] events_i,

  cnt_csr_if.bank                bus
);

  logic [NumCounters-1:0] inhibit_q;
  logic [NumCounters-1:0] cnt_event;
  logic [NumCounters-1:0] cnt_inc;
  logic [CntValW-1:0]     cnt_vals [NumCounters];

  // Inhibit register takes the low bits of the new value
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
    end else if (bus.inhibit_we) begin
      inhibit_q <= bus.wdata[NumCounters-1:0];
    end
  end

  // Cycle counter event is tied high
  assign cnt_event = {events_i, 1'b1};
  assign cnt_inc   = cnt_event & ~inhibit_q;

  for (genvar k = 0; k < NumCounters; k++) begin : g_cnt
    // mcycle and minstret always full width
    localparam int Width = (k < 2) ? CntValW : CounterWidth;

    perf_counter #(
      .CounterWidth (Width)
    ) u_counter (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .counter_inc_i (cnt_inc[k]),
      .counter_we_i  (bus.we_lo[k]),
      .counterh_we_i (bus.we_hi[k]),
      .counter_val_i (bus.wdata),
      .counter_val_o (cnt_vals[k])
    );

    // Inhibited and unwritten means frozen
    a_inhibit_holds: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (inhibit_q[k] && !bus.we_lo[k] && !bus.we_hi[k]) |=> $stable(cnt_vals[k])
    );
  end

  assign bus.cnt_vals = cnt_vals;
  assign bus.inhibit  = inhibit_q;

endmodule

// ==== src/csr_read_mux.sv ====
// **************************************************
// Counter CSR read path
// Word select, registered read data and flags
// **************************************************

`timescale 1ns/1ps

module csr_read_mux import perf_cnt_pkg::*; #(
  parameter int NumCounters = 5
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                csr_access_i,

  output logic [CsrDataW-1:0] csr_rdata_o,
  output logic                csr_rvalid_o,
  output logic                csr_illegal_o,

  cnt_csr_if.readout          bus
);

  logic [CsrDataW-1:0] sel_word;
  logic [CsrDataW-1:0] rdata_q;
  logic                rvalid_q;
  logic                illegal_q;

  // Unmapped addresses read as zero
  always_comb begin
    if (bus.rd_illegal) begin
      sel_word = '0;
    end else if (bus.rd_inhibit) begin
      sel_word = CsrDataW'(bus.inhibit);
    end else if (bus.rd_hi) begin
      sel_word = bus.cnt_vals[bus.rd_sel][CntValW-1:CsrDataW];
    end else begin
      sel_word = bus.cnt_vals[bus.rd_sel][CsrDataW-1:0];
    end
  end

  // Captures the pre-write value at the access edge
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rdata_q   <= '0;
      rvalid_q  <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      rdata_q   <= csr_access_i ? sel_word : '0;
      rvalid_q  <= csr_access_i;
      illegal_q <= csr_access_i & bus.rd_illegal;
    end
  end

  assign csr_rdata_o   = rdata_q;
  assign csr_rvalid_o  = rvalid_q;
  assign csr_illegal_o = illegal_q;

  a_rvalid_follows_access: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    csr_rvalid_o |-> $past(csr_access_i)
  );

endmodule

// ==== src/perf_cnt_top.sv ====
// **************************************************
// Performance counter unit top level
// CSR decode, counter bank and read path
// **************************************************

`timescale 1ns/1ps

module perf_cnt_top import perf_cnt_pkg::*; #(
  parameter int NumCounters  = 5,
  parameter int CounterWidth = 40
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // CSR access port
  input  logic                   csr_access_i,
  input  csr_op_e                csr_op_i,
  input  logic [CsrAddrW-1:0]    csr_addr_i,
  input  logic [CsrDataW-1:0]    csr_wdata_i,

  // Hardware events, counter 1 upwards
  input  logic [NumCounters-2:0] events_i,

  output logic [CsrDataW-1:0]    csr_rdata_o,
  output logic                   csr_rvalid_o,
  output logic                   csr_illegal_o
);

  cnt_csr_if #(.NumCounters(NumCounters)) cnt_bus ();

  csr_access_decode #(
    .NumCounters (NumCounters)
  ) u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_access_i (csr_access_i),
    .csr_op_i     (csr_op_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .bus          (cnt_bus.decode)
  );

  counter_bank #(
    .NumCounters  (NumCounters),
    .CounterWidth (CounterWidth)
  ) u_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .events_i (events_i),
    .bus      (cnt_bus.bank)
  );

  csr_read_mux #(
    .NumCounters (NumCounters)
  ) u_readout (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_access_i  (csr_access_i),
    .csr_rdata_o   (csr_rdata_o),
    .csr_rvalid_o  (csr_rvalid_o),
    .csr_illegal_o (csr_illegal_o),
    .bus           (cnt_bus.readout)
  );

endmodule

// ==== testbench/tb_perf_cnt.sv ====
// **************************************************
// Performance counter unit testbench
// Table of CSR accesses checked at each read pulse
// **************************************************

`timescale 1ns/1ps

module tb_perf_cnt import perf_cnt_pkg::*; ();

  localparam int EvW = 4;

  typedef struct packed {
    csr_op_e             op;
    logic [CsrAddrW-1:0] addr;
    logic [CsrDataW-1:0] wdata;
    logic [EvW-1:0]      ev;
    logic                rnd;
    logic [CsrDataW-1:0] exp_data;
    logic                exp_ill;
  } entry_t;

  logic                clk_i;
  logic                rst_ni;
  logic                csr_access_i;
  csr_op_e             csr_op_i;
  logic [CsrAddrW-1:0] csr_addr_i;
  logic [CsrDataW-1:0] csr_wdata_i;
  logic [EvW-1:0]      events_i;
  logic [CsrDataW-1:0] csr_rdata_o;
  logic                csr_rvalid_o;
  logic                csr_illegal_o;

  entry_t         tests [$];
  entry_t         cur;
  csr_op_e        cur_op;
  logic [7:0]     lfsr;
  logic [EvW-1:0] rand_ev;
  int             errors;
  int             errors_before;
  int             failed;
  int             late;
  int             cycle_cnt;
  int             cycle_limit;

  perf_cnt_top uut (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // Each entry takes an access cycle and an idle cycle
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: test table not finished after %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // 8-bit Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic add_entry(input csr_op_e op, input logic [CsrAddrW-1:0] addr,
                           input logic [CsrDataW-1:0] wdata, input logic [EvW-1:0] ev,
                           input logic rnd, input logic [CsrDataW-1:0] exp_data,
                           input logic exp_ill);
    entry_t e;
    e.op       = op;
    e.addr     = addr;
    e.wdata    = wdata;
    e.ev       = ev;
    e.rnd      = rnd;
    e.exp_data = exp_data;
    e.exp_ill  = exp_ill;
    tests.push_back(e);
  endtask

  task automatic check_data(input string sig, input logic [CsrDataW-1:0] got,
                            input logic [CsrDataW-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%08h, expected 0x%08h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", sig, got, exp);
      errors++;
    end
  endtask

  // Expected values are the word before each access takes effect
  task automatic fill_table();
    // After reset, then freeze everything (mcycle stops at 3)
    add_entry(CSR_READ,  12'hB00, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_SET,   12'h320, 32'h0000_001F, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB80, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB02, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB82, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB03, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB83, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB04, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB84, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB05, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'h320, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_001F, 1'b0);
    // All inhibited, random events, 40-bit counter 2
    add_entry(CSR_WRITE, 12'hB03, 32'h1234_5678, 4'b0000, 1'b1, 32'h0000_0000, 1'b0);
    add_entry(CSR_SET,   12'hB03, 32'h0000_0F00, 4'b0000, 1'b1, 32'h1234_5678, 1'b0);
    add_entry(CSR_CLEAR, 12'hB03, 32'h0000_0078, 4'b0000, 1'b1, 32'h1234_5F78, 1'b0);
    add_entry(CSR_WRITE, 12'hB83, 32'h0000_00A5, 4'b0000, 1'b1, 32'h0000_0000, 1'b0);
    add_entry(CSR_SET,   12'hB83, 32'hFFFF_FF5A, 4'b0000, 1'b1, 32'h0000_00A5, 1'b0);
    add_entry(CSR_CLEAR, 12'hB83, 32'h0000_000F, 4'b0000, 1'b1, 32'h0000_00FF, 1'b0);
    add_entry(CSR_READ,  12'hB83, 32'h0000_0000, 4'b0000, 1'b1, 32'h0000_00F0, 1'b0);
    add_entry(CSR_READ,  12'hB00, 32'h0000_0000, 4'b0000, 1'b1, 32'h0000_0003, 1'b0);
    // Cycle counter runs with one idle edge between accesses
    add_entry(CSR_CLEAR, 12'h320, 32'h0000_0001, 4'b0000, 1'b1, 32'h0000_001F, 1'b0);
    add_entry(CSR_WRITE, 12'hB00, 32'h0000_1000, 4'b0000, 1'b1, 32'h0000_0004, 1'b0);
    add_entry(CSR_READ,  12'hB00, 32'h0000_0000, 4'b0000, 1'b1, 32'h0000_1001, 1'b0);
    add_entry(CSR_WRITE, 12'hB00, 32'hFFFF_FFFF, 4'b0000, 1'b1, 32'h0000_1003, 1'b0);
    add_entry(CSR_READ,  12'hB80, 32'h0000_0000, 4'b0000, 1'b1, 32'h0000_0001, 1'b0);
    add_entry(CSR_READ,  12'hB00, 32'h0000_0000, 4'b0000, 1'b1, 32'h0000_0002, 1'b0);
    // Event counters enabled, events only in access cycles
    add_entry(CSR_WRITE, 12'h320, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_001E, 1'b0);
    add_entry(CSR_READ,  12'hB04, 32'h0000_0000, 4'b0101, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB04, 32'h0000_0000, 4'b1100, 1'b0, 32'h0000_0001, 1'b0);
    add_entry(CSR_READ,  12'hB05, 32'h0000_0000, 4'b1111, 1'b0, 32'h0000_0001, 1'b0);
    add_entry(CSR_READ,  12'hB02, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0002, 1'b0);
    add_entry(CSR_READ,  12'hB03, 32'h0000_0000, 4'b0000, 1'b0, 32'h1234_5F01, 1'b0);
    add_entry(CSR_WRITE, 12'hB04, 32'h0000_0000, 4'b0100, 1'b0, 32'h0000_0003, 1'b0);
    add_entry(CSR_READ,  12'hB04, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_WRITE, 12'hB85, 32'h0000_00FF, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_WRITE, 12'hB05, 32'hFFFF_FFFF, 4'b0000, 1'b0, 32'h0000_0002, 1'b0);
    add_entry(CSR_READ,  12'hB85, 32'h0000_0000, 4'b1000, 1'b0, 32'h0000_00FF, 1'b0);
    add_entry(CSR_READ,  12'hB05, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    add_entry(CSR_READ,  12'hB85, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    // Unmapped addresses
    add_entry(CSR_READ,  12'hB01, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b1);
    add_entry(CSR_WRITE, 12'hB81, 32'h0000_1234, 4'b0000, 1'b0, 32'h0000_0000, 1'b1);
    add_entry(CSR_SET,   12'h321, 32'h0000_FFFF, 4'b0000, 1'b0, 32'h0000_0000, 1'b1);
    add_entry(CSR_READ,  12'h320, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0000, 1'b0);
    // mcycle high word is still 1 after the write to 0xB81
    add_entry(CSR_READ,  12'hB80, 32'h0000_0000, 4'b0000, 1'b0, 32'h0000_0001, 1'b0);
  endtask

  initial begin
    errors       = 0;
    failed       = 0;
    cycle_cnt    = 0;
    lfsr         = 8'd73;
    rand_ev      = '0;
    rst_ni       = 1'b0;
    csr_access_i = 1'b0;
    csr_op_i     = CSR_READ;
    csr_addr_i   = '0;
    csr_wdata_i  = '0;
    events_i     = '0;
    fill_table();
    cycle_limit = tests.size() * 4 + 20;

    repeat (3) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;

    for (int i = 0; i < tests.size(); i++) begin
      cur           = tests[i];
      errors_before = errors;
      // Previous pulse lasts one cycle only
      check_flag("csr_rvalid_o", csr_rvalid_o, 1'b0);
      if (cur.rnd) begin
        repeat (EvW) begin
          lfsr    = lfsr_next(lfsr);
          rand_ev = {rand_ev[EvW-2:0], lfsr[0]};
        end
        events_i = rand_ev;
      end else begin
        events_i = cur.ev;
      end
      csr_access_i = 1'b1;
      csr_op_i     = cur.op;
      csr_addr_i   = cur.addr;
      csr_wdata_i  = cur.wdata;

      @(posedge clk_i);
      #5;
      csr_access_i = 1'b0;
      events_i     = '0;
      late         = 0;
      while (!csr_rvalid_o) begin
        late++;
        @(posedge clk_i);
        #5;
      end
      if (late != 0) begin
        $display("Test %0d: read data valid came %0d cycles late", i, late);
        errors++;
      end
      check_data("csr_rdata_o", csr_rdata_o, cur.exp_data);
      check_flag("csr_illegal_o", csr_illegal_o, cur.exp_ill);

      cur_op = cur.op;
      if (errors == errors_before) begin
        $display("Test %0d: %s at 0x%03h ok", i, cur_op.name(), cur.addr);
      end else begin
        failed++;
        $display("Test %0d: %s at 0x%03h wrong", i, cur_op.name(), cur.addr);
      end
      @(posedge clk_i);
      #5;
    end

    $display("Done: %0d tests, %0d passed, %0d failed", tests.size(),
             tests.size() - failed, failed);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
src/perf_cnt_pkg.sv
src/cnt_csr_if.sv
src/perf_counter.sv
src/csr_access_decode.sv
src/counter_bank.sv
src/csr_read_mux.sv
src/perf_cnt_top.sv
testbench/tb_perf_cnt.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the performance counter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module tb_perf_cnt -Mdir obj_dir -o tb_perf_cnt
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_perf_cnt > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

exit 0
